// ==== design/vaddr_pkg.sv ====
// Vector address generator package with shared widths, limits, enums and payload structs
`default_nettype none

package vaddr_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and limits
  ////////////////////////////////////////////////////////////////////////////

  // Physical byte address width
  localparam int unsigned AddrWidth      = 32;
  // Element count width
  localparam int unsigned VlWidth        = 16;
  // Data bus width in bytes, and its log2 for the AXI size field
  localparam int unsigned AxiDataBytes   = 8;
  localparam int unsigned AxiSizeLog     = 3;
  // AXI incrementing bursts are limited to 256 beats
  localparam int unsigned MaxBurstBeats  = 256;
  // 4 KiB pages, a burst must stay inside one
  localparam int unsigned PageOffsetBits = 12;
  // Command queue towards the load/store units
  localparam int unsigned LsuQueueDepth  = 4;
  localparam int unsigned LsuPtrWidth    = $clog2(LsuQueueDepth);
  // One extra bit so that a full queue can be counted
  localparam int unsigned LsuCntWidth    = $clog2(LsuQueueDepth + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [VlWidth-1:0]     vlen_t;
  typedef logic [AddrWidth-1:0]   stride_t;
  // AXI length field holds beats minus one
  typedef logic [7:0]             beat_len_t;
  typedef logic [2:0]             ax_size_t;
  typedef logic [LsuPtrWidth-1:0] lsu_ptr_t;
  typedef logic [LsuCntWidth-1:0] lsu_cnt_t;

  // Element width, encoded as log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  ////////////////////////////////////////////////////////////////////////////
  // Payload structs
  ////////////////////////////////////////////////////////////////////////////

  // Vector memory instruction as it enters the unit
  typedef struct packed {
    addr_t   addr;
    vlen_t   vl;
    stride_t stride;
    vew_e    vew;
    logic    is_load;
    // Unit-stride accesses turn into incrementing bursts
    logic    unit_stride;
  } vec_req_t;

  // Checked instruction, handed from the frontend to the splitter
  typedef struct packed {
    addr_t   addr;
    vlen_t   vl;
    stride_t stride;
    vew_e    vew;
    logic    is_load;
    logic    unit_stride;
  } mem_desc_t;

  // AR/AW channel payload
  typedef struct packed {
    addr_t     addr;
    beat_len_t len;
    ax_size_t  size;
  } ax_req_t;

  // Command for the load/store units, one per issued AR/AW request
  typedef struct packed {
    addr_t     addr;
    beat_len_t len;
    ax_size_t  size;
    logic      is_load;
  } lsu_cmd_t;

endpackage

`default_nettype wire

// ==== design/vaddr_frontend.sv ====
// Instruction frontend, registers a vector memory request, checks alignment and acknowledges
`timescale 1ns/1ns
`default_nettype none

module vaddr_frontend (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  // Instruction interface
  input  vaddr_pkg::vec_req_t       req_i,
  input  wire logic                 req_valid_i,
  output logic                      req_ready_o,
  // Descriptor towards the burst splitter
  output vaddr_pkg::mem_desc_t      desc_o,
  output logic                      desc_valid_o,
  input  wire logic                 desc_ready_i,
  input  wire logic                 done_i,
  // Completion report
  output logic                      ack_o,
  output logic                      error_o
);

  typedef enum logic [2:0] {
    IDLE,
    CHECK,
    ISSUE,
    WAIT_DONE,
    REPLY
  } state_e;

  state_e               state_q, state_d;
  vaddr_pkg::mem_desc_t req_q;
  logic                 err_q, err_d;
  logic                 ready_q;
  logic                 accept;

  // Any set address bit below log2 of the element size is a misalignment
  function automatic logic is_misaligned(vaddr_pkg::addr_t addr, vaddr_pkg::vew_e vew);
    vaddr_pkg::addr_t mask;
    mask = (vaddr_pkg::addr_t'(1) << vew) - vaddr_pkg::addr_t'(1);
    return |(addr & mask);
  endfunction

  assign accept = req_valid_i && ready_q;

  always_comb begin
    state_d = state_q;
    err_d   = err_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = CHECK;
        end
      end
      CHECK: begin
        // Misaligned requests skip the splitter and reply right away
        err_d   = is_misaligned(req_q.addr, req_q.vew);
        state_d = err_d ? REPLY : ISSUE;
      end
      ISSUE: begin
        if (desc_ready_i) begin
          state_d = WAIT_DONE;
        end
      end
      WAIT_DONE: begin
        if (done_i) begin
          state_d = REPLY;
        end
      end
      REPLY: begin
        state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      err_q   <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
      // Ready follows the idle state one edge late, so it stays low in reset
      ready_q <= (state_d == IDLE);
    end
  end

  // Instruction register
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q.addr        <= req_i.addr;
      req_q.vl          <= req_i.vl;
      req_q.stride      <= req_i.stride;
      req_q.vew         <= req_i.vew;
      req_q.is_load     <= req_i.is_load;
      req_q.unit_stride <= req_i.unit_stride;
    end
  end

  assign req_ready_o  = ready_q;
  assign desc_o       = req_q;
  assign desc_valid_o = (state_q == ISSUE);
  assign ack_o        = (state_q == REPLY);
  assign error_o      = (state_q == REPLY) && err_q;

endmodule

`default_nettype wire

// ==== design/burst_splitter.sv ====
// Burst splitter, turns a descriptor into page-safe AR/AW bursts or strided single beats
`timescale 1ns/1ns
`default_nettype none

module burst_splitter (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  // Descriptor from the frontend
  input  vaddr_pkg::mem_desc_t      desc_i,
  input  wire logic                 desc_valid_i,
  output logic                      desc_ready_o,
  output logic                      done_o,
  // Read address channel
  output vaddr_pkg::ax_req_t        ar_o,
  output logic                      ar_valid_o,
  input  wire logic                 ar_ready_i,
  // Write address channel
  output vaddr_pkg::ax_req_t        aw_o,
  output logic                      aw_valid_o,
  input  wire logic                 aw_ready_i,
  // Command queue push side and status
  output logic                      push_o,
  output vaddr_pkg::lsu_cmd_t       push_cmd_o,
  input  vaddr_pkg::lsu_cmd_t       q_head_i,
  input  wire logic                 q_empty_i,
  input  wire logic                 q_full_i
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    REQUEST,
    NEXT
  } state_e;

  state_e             state_q, state_d;
  logic               done_q, done_d;

  // Descriptor fields that stay constant for the whole instruction
  logic               is_load_q;
  logic               unit_stride_q;
  vaddr_pkg::vew_e    vew_q;
  vaddr_pkg::stride_t stride_q;

  // Running address, remaining elements and the current chunk end
  vaddr_pkg::addr_t   cur_addr_q, cur_addr_d;
  vaddr_pkg::vlen_t   remaining_q, remaining_d;
  vaddr_pkg::addr_t   chunk_end_q, chunk_end_d;

  vaddr_pkg::addr_t   beat_mask;
  vaddr_pkg::addr_t   aligned_start;
  vaddr_pkg::addr_t   vec_end;
  vaddr_pkg::addr_t   burst_end;
  vaddr_pkg::addr_t   page_end;
  vaddr_pkg::addr_t   chunk_lim;
  vaddr_pkg::addr_t   chunk_elems;
  logic               last_chunk;

  vaddr_pkg::ax_req_t ax_req;
  logic               order_ok;
  logic               issue_ok;
  logic               ax_ready;
  logic               handshake;

  ////////////////////////////////////////////////////////////////////////////
  // Chunk limit
  ////////////////////////////////////////////////////////////////////////////

  assign beat_mask     = vaddr_pkg::addr_t'(vaddr_pkg::AxiDataBytes - 1);
  assign aligned_start = cur_addr_q & ~beat_mask;

  // Last bus beat that still holds an element of the vector
  assign vec_end = (cur_addr_q + (vaddr_pkg::addr_t'(remaining_q) << vew_q)
                    - vaddr_pkg::addr_t'(1)) | beat_mask;
  // Last byte of a maximum-length burst
  assign burst_end = aligned_start
                   + vaddr_pkg::addr_t'(vaddr_pkg::MaxBurstBeats * vaddr_pkg::AxiDataBytes)
                   - vaddr_pkg::addr_t'(1);
  // Last byte of the current page
  assign page_end = {cur_addr_q[vaddr_pkg::AddrWidth-1:vaddr_pkg::PageOffsetBits],
                     {vaddr_pkg::PageOffsetBits{1'b1}}};

  always_comb begin
    chunk_lim = vec_end;
    if (burst_end < chunk_lim) begin
      chunk_lim = burst_end;
    end
    if (page_end < chunk_lim) begin
      chunk_lim = page_end;
    end
  end

  // Elements inside the registered chunk, the start is element aligned
  assign chunk_elems = (chunk_end_q - cur_addr_q + vaddr_pkg::addr_t'(1)) >> vew_q;
  assign last_chunk  = chunk_elems >= vaddr_pkg::addr_t'(remaining_q);

  ////////////////////////////////////////////////////////////////////////////
  // Request issue
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ax_req.addr = cur_addr_q;
    if (unit_stride_q) begin
      ax_req.len  = vaddr_pkg::beat_len_t'((chunk_end_q - aligned_start) >>
                                           vaddr_pkg::AxiSizeLog);
      ax_req.size = vaddr_pkg::ax_size_t'(vaddr_pkg::AxiSizeLog);
    end else begin
      // One element per request, sized to the element
      ax_req.len  = '0;
      ax_req.size = vaddr_pkg::ax_size_t'(vew_q);
    end
  end

  // Channel switch only once the queue holds nothing of the other direction
  assign order_ok  = q_empty_i || (q_head_i.is_load == is_load_q);
  assign issue_ok  = (state_q == REQUEST) && !q_full_i && order_ok;
  assign ax_ready  = is_load_q ? ar_ready_i : aw_ready_i;
  assign handshake = issue_ok && ax_ready;

  assign ar_o       = ax_req;
  assign aw_o       = ax_req;
  assign ar_valid_o = issue_ok && is_load_q;
  assign aw_valid_o = issue_ok && !is_load_q;

  // Every handshake leaves a matching command for the load/store units
  assign push_o             = handshake;
  assign push_cmd_o.addr    = ax_req.addr;
  assign push_cmd_o.len     = ax_req.len;
  assign push_cmd_o.size    = ax_req.size;
  assign push_cmd_o.is_load = is_load_q;

  assign desc_ready_o = (state_q == IDLE);
  assign done_o       = done_q;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    done_d      = 1'b0;
    cur_addr_d  = cur_addr_q;
    remaining_d = remaining_q;
    chunk_end_d = chunk_end_q;
    case (state_q)
      IDLE: begin
        if (desc_valid_i) begin
          cur_addr_d  = desc_i.addr;
          remaining_d = desc_i.vl;
          state_d     = SETUP;
        end
      end
      SETUP, NEXT: begin
        chunk_end_d = chunk_lim;
        // Empty vector, nothing to issue
        if (remaining_q == '0) begin
          done_d  = 1'b1;
          state_d = IDLE;
        end else begin
          state_d = REQUEST;
        end
      end
      REQUEST: begin
        if (handshake) begin
          if (unit_stride_q) begin
            cur_addr_d  = chunk_end_q + vaddr_pkg::addr_t'(1);
            remaining_d = last_chunk ? '0 : remaining_q - vaddr_pkg::vlen_t'(chunk_elems);
            done_d      = last_chunk;
          end else begin
            cur_addr_d  = cur_addr_q + stride_q;
            remaining_d = remaining_q - vaddr_pkg::vlen_t'(1);
            done_d      = (remaining_q == vaddr_pkg::vlen_t'(1));
          end
          state_d = done_d ? IDLE : NEXT;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    cur_addr_q  <= cur_addr_d;
    remaining_q <= remaining_d;
    chunk_end_q <= chunk_end_d;
    if (desc_valid_i && desc_ready_o) begin
      is_load_q     <= desc_i.is_load;
      unit_stride_q <= desc_i.unit_stride;
      vew_q         <= desc_i.vew;
      stride_q      <= desc_i.stride;
    end
  end

endmodule

`default_nettype wire

// ==== design/lsu_cmd_queue.sv ====
// Command queue, circular buffer of issued AR/AW commands for the load/store units
`timescale 1ns/1ns
`default_nettype none

module lsu_cmd_queue (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  // Push side from the splitter
  input  wire logic                 push_i,
  input  vaddr_pkg::lsu_cmd_t       cmd_i,
  output logic                      full_o,
  output logic                      empty_o,
  output vaddr_pkg::lsu_cmd_t       head_o,
  // Pop side towards the load/store units
  output vaddr_pkg::lsu_cmd_t       lsu_cmd_o,
  output logic                      lsu_cmd_valid_o,
  input  wire logic                 lsu_cmd_ready_i
);

  vaddr_pkg::lsu_cmd_t mem_q [vaddr_pkg::LsuQueueDepth];
  vaddr_pkg::lsu_ptr_t wr_ptr_q, rd_ptr_q;
  vaddr_pkg::lsu_cnt_t count_q;
  logic                do_push, do_pop;

  // Pointer step with wrap at the last entry
  function automatic vaddr_pkg::lsu_ptr_t ptr_inc(vaddr_pkg::lsu_ptr_t ptr);
    if (ptr == vaddr_pkg::lsu_ptr_t'(vaddr_pkg::LsuQueueDepth - 1)) begin
      return '0;
    end
    return ptr + vaddr_pkg::lsu_ptr_t'(1);
  endfunction

  assign full_o  = (count_q == vaddr_pkg::lsu_cnt_t'(vaddr_pkg::LsuQueueDepth));
  assign empty_o = (count_q == '0);

  assign do_push = push_i && !full_o;
  assign do_pop  = lsu_cmd_valid_o && lsu_cmd_ready_i;

  // Head is shared by the splitter ordering check and the pop side
  assign head_o          = mem_q[rd_ptr_q];
  assign lsu_cmd_o       = mem_q[rd_ptr_q];
  assign lsu_cmd_valid_o = !empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Simultaneous push and pop leaves the fill level unchanged
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + vaddr_pkg::lsu_cnt_t'(1);
        2'b01:   count_q <= count_q - vaddr_pkg::lsu_cnt_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= cmd_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/vaddr_gen_top.sv ====
// Vector memory address generator top, frontend into burst splitter with command queue
`timescale 1ns/1ns
`default_nettype none

module vaddr_gen_top (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  // Instruction interface
  input  vaddr_pkg::vec_req_t       req_i,
  input  wire logic                 req_valid_i,
  output logic                      req_ready_o,
  output logic                      ack_o,
  output logic                      error_o,
  // Read and write address channels
  output vaddr_pkg::ax_req_t        ar_o,
  output logic                      ar_valid_o,
  input  wire logic                 ar_ready_i,
  output vaddr_pkg::ax_req_t        aw_o,
  output logic                      aw_valid_o,
  input  wire logic                 aw_ready_i,
  // Commands for the load/store units
  output vaddr_pkg::lsu_cmd_t       lsu_cmd_o,
  output logic                      lsu_cmd_valid_o,
  input  wire logic                 lsu_cmd_ready_i
);

  // Frontend to splitter
  vaddr_pkg::mem_desc_t desc;
  logic                 desc_valid;
  logic                 desc_ready;
  logic                 done;

  // Splitter to queue
  logic                 push;
  vaddr_pkg::lsu_cmd_t  push_cmd;
  vaddr_pkg::lsu_cmd_t  q_head;
  logic                 q_empty;
  logic                 q_full;

  vaddr_frontend u_frontend (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .desc_o       (desc),
    .desc_valid_o (desc_valid),
    .desc_ready_i (desc_ready),
    .done_i       (done),
    .ack_o        (ack_o),
    .error_o      (error_o)
  );

  burst_splitter u_splitter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .desc_i       (desc),
    .desc_valid_i (desc_valid),
    .desc_ready_o (desc_ready),
    .done_o       (done),
    .ar_o         (ar_o),
    .ar_valid_o   (ar_valid_o),
    .ar_ready_i   (ar_ready_i),
    .aw_o         (aw_o),
    .aw_valid_o   (aw_valid_o),
    .aw_ready_i   (aw_ready_i),
    .push_o       (push),
    .push_cmd_o   (push_cmd),
    .q_head_i     (q_head),
    .q_empty_i    (q_empty),
    .q_full_i     (q_full)
  );

  lsu_cmd_queue u_cmd_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .push_i          (push),
    .cmd_i           (push_cmd),
    .full_o          (q_full),
    .empty_o         (q_empty),
    .head_o          (q_head),
    .lsu_cmd_o       (lsu_cmd_o),
    .lsu_cmd_valid_o (lsu_cmd_valid_o),
    .lsu_cmd_ready_i (lsu_cmd_ready_i)
  );

endmodule

`default_nettype wire

// ==== testbench/vaddr_gen_props.sv ====
// Handshake, queue limit and ack properties for the vector address generator top
`timescale 1ns/1ns
`default_nettype none

module vaddr_gen_props (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  vaddr_pkg::ax_req_t        ar_i,
  input  wire logic                 ar_valid_i,
  input  wire logic                 ar_ready_i,
  input  vaddr_pkg::ax_req_t        aw_i,
  input  wire logic                 aw_valid_i,
  input  wire logic                 aw_ready_i,
  input  wire logic                 push_i,
  input  wire logic                 q_full_i,
  input  wire logic                 ack_i,
  input  wire logic                 error_i
);

  // AR request held with a stable payload until it is taken
  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
    else $error("AR request dropped or changed before ready");

  // Same for AW
  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
    else $error("AW request dropped or changed before ready");

  no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !q_full_i)
    else $error("Command pushed into a full queue");

  // Completion is a single cycle pulse
  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_i |=> !ack_i)
    else $error("Ack held longer than one cycle");

  error_with_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    error_i |-> ack_i)
    else $error("Error raised without ack");

endmodule

bind vaddr_gen_top vaddr_gen_props u_props (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .ar_i       (ar_o),
  .ar_valid_i (ar_valid_o),
  .ar_ready_i (ar_ready_i),
  .aw_i       (aw_o),
  .aw_valid_i (aw_valid_o),
  .aw_ready_i (aw_ready_i),
  .push_i     (push),
  .q_full_i   (q_full),
  .ack_i      (ack_o),
  .error_i    (error_o)
);

`default_nettype wire

// ==== testbench/tb_vaddr_gen.sv ====
// Testbench for the vector address generator, directed tests against AR/AW and queue models
`timescale 1ns/1ns
`default_nettype none

module tb_vaddr_gen;

  localparam int WaitLimit = 2000;
  // Modes of the queue ready line
  localparam int LsuHold   = 0;
  localparam int LsuOpen   = 1;
  localparam int LsuRandom = 2;

  logic                clk;
  logic                rst_n;
  vaddr_pkg::vec_req_t req;
  logic                req_valid;
  logic                req_ready;
  logic                ack;
  logic                err;
  vaddr_pkg::ax_req_t  ar;
  logic                ar_valid;
  logic                ar_ready;
  vaddr_pkg::ax_req_t  aw;
  logic                aw_valid;
  logic                aw_ready;
  vaddr_pkg::lsu_cmd_t lsu_cmd;
  logic                lsu_cmd_valid;
  logic                lsu_cmd_ready;

  integer seed = 64;
  logic   rand_ready;
  int     lsu_mode;
  int     errors;
  int     checks;

  // Handshakes seen by the monitor, and the expected queue contents
  vaddr_pkg::ax_req_t  ar_log[$];
  vaddr_pkg::ax_req_t  aw_log[$];
  vaddr_pkg::lsu_cmd_t queue_model[$];

  vaddr_gen_top UUT (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .req_i           (req),
    .req_valid_i     (req_valid),
    .req_ready_o     (req_ready),
    .ack_o           (ack),
    .error_o         (err),
    .ar_o            (ar),
    .ar_valid_o      (ar_valid),
    .ar_ready_i      (ar_ready),
    .aw_o            (aw),
    .aw_valid_o      (aw_valid),
    .aw_ready_i      (aw_ready),
    .lsu_cmd_o       (lsu_cmd),
    .lsu_cmd_valid_o (lsu_cmd_valid),
    .lsu_cmd_ready_i (lsu_cmd_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic void report_error(string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    errors++;
  endfunction

  function automatic void check_value(string what, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      report_error($sformatf("%s is 0x%0h, expected 0x%0h", what, got, exp));
    end
  endfunction

  function automatic vaddr_pkg::lsu_cmd_t to_cmd(vaddr_pkg::ax_req_t ax, logic is_load);
    vaddr_pkg::lsu_cmd_t cmd;
    cmd.addr    = ax.addr;
    cmd.len     = ax.len;
    cmd.size    = ax.size;
    cmd.is_load = is_load;
    return cmd;
  endfunction

  function automatic void clear_logs();
    ar_log.delete();
    aw_log.delete();
  endfunction

  // Ready lines change once per cycle, shortly after the rising edge
  always @(posedge clk) begin
    #2;
    ar_ready      = rand_ready ? 1'($random(seed)) : 1'b1;
    aw_ready      = rand_ready ? 1'($random(seed)) : 1'b1;
    lsu_cmd_ready = (lsu_mode == LsuRandom) ? 1'($random(seed)) : (lsu_mode == LsuOpen);
  end

  // Monitor samples at the falling edge, where every handshake input is settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (aw_valid && aw_ready) begin
        foreach (queue_model[i]) begin
          if (queue_model[i].is_load) begin
            report_error("AW request issued while load commands are still queued");
          end
        end
      end
      // Pops leave in the order of the AR/AW handshakes
      if (lsu_cmd_valid && lsu_cmd_ready) begin
        checks++;
        if (queue_model.size() == 0) begin
          report_error("queue command popped with no matching AR/AW handshake");
        end else begin
          if (lsu_cmd !== queue_model[0]) begin
            report_error($sformatf("queue command 0x%0h, expected 0x%0h",
                                   lsu_cmd, queue_model[0]));
          end
          void'(queue_model.pop_front());
        end
      end
      if (ar_valid && ar_ready) begin
        ar_log.push_back(ar);
        queue_model.push_back(to_cmd(ar, 1'b1));
      end
      if (aw_valid && aw_ready) begin
        aw_log.push_back(aw);
        queue_model.push_back(to_cmd(aw, 1'b0));
      end
      if (queue_model.size() > vaddr_pkg::LsuQueueDepth) begin
        report_error("more commands issued than the queue can hold");
      end
    end
  end

  task automatic send_req(input vaddr_pkg::addr_t addr, input vaddr_pkg::vlen_t vl,
                          input vaddr_pkg::stride_t stride, input vaddr_pkg::vew_e vew,
                          input logic is_load, input logic unit_stride);
    int t;
    @(posedge clk);
    #2;
    req.addr        = addr;
    req.vl          = vl;
    req.stride      = stride;
    req.vew         = vew;
    req.is_load     = is_load;
    req.unit_stride = unit_stride;
    req_valid       = 1'b1;
    t = 0;
    @(negedge clk);
    while (!req_ready && t < WaitLimit) begin
      @(negedge clk);
      t++;
    end
    if (!req_ready) begin
      report_error("request was not accepted within the wait limit");
    end
    @(posedge clk);
    #2;
    req_valid = 1'b0;
  endtask

  task automatic wait_ack(output logic got_err);
    int t;
    t = 0;
    got_err = 1'b0;
    @(negedge clk);
    while (!ack && t < WaitLimit) begin
      @(negedge clk);
      t++;
    end
    if (ack) begin
      got_err = err;
    end else begin
      report_error("no ack from the DUT within the wait limit");
    end
  endtask

  task automatic wait_ar_count(input int n);
    int t;
    t = 0;
    while (ar_log.size() < n && t < WaitLimit) begin
      @(negedge clk);
      t++;
    end
    if (ar_log.size() < n) begin
      report_error("too few AR handshakes within the wait limit");
    end
  endtask

  // Queue must empty once the load/store side accepts commands
  task automatic wait_drained();
    int t;
    t = 0;
    @(negedge clk);
    while ((queue_model.size() != 0 || lsu_cmd_valid) && t < WaitLimit) begin
      @(negedge clk);
      t++;
    end
    if (queue_model.size() != 0 || lsu_cmd_valid) begin
      report_error("command queue did not drain within the wait limit");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_single_burst();
    vaddr_pkg::addr_t base;
    logic             got_err;
    int               beats;
    // Word aligned but not bus aligned, inside one page
    base  = 32'h1000_0124;
    beats = (int'(base & 32'h7) + 20 * 4 + 7) / 8;
    clear_logs();
    send_req(base, 16'd20, '0, vaddr_pkg::EW32, 1'b1, 1'b1);
    wait_ack(got_err);
    check_value("single burst error", 32'(got_err), 32'd0);
    check_value("single burst AR count", ar_log.size(), 32'd1);
    check_value("single burst AW count", aw_log.size(), 32'd0);
    if (ar_log.size() == 1) begin
      check_value("single burst address", ar_log[0].addr, base);
      check_value("single burst size", 32'(ar_log[0].size), 32'd3);
      check_value("single burst length", 32'(ar_log[0].len), 32'(beats - 1));
    end
    wait_drained();
  endtask

  task automatic test_page_cross();
    vaddr_pkg::addr_t base;
    logic             got_err;
    int               first_beats;
    base        = 32'h2000_0FC0;
    first_beats = (4096 - int'(base & 32'hFFF)) / 8;
    clear_logs();
    send_req(base, 16'd32, '0, vaddr_pkg::EW64, 1'b0, 1'b1);
    wait_ack(got_err);
    check_value("page cross error", 32'(got_err), 32'd0);
    check_value("page cross AW count", aw_log.size(), 32'd2);
    if (aw_log.size() == 2) begin
      check_value("first burst address", aw_log[0].addr, base);
      check_value("first burst length", 32'(aw_log[0].len), 32'(first_beats - 1));
      check_value("second burst address", aw_log[1].addr, (base | 32'hFFF) + 32'd1);
      // 32 doublewords are 32 beats in total
      check_value("page cross total beats",
                  32'(int'(aw_log[0].len) + int'(aw_log[1].len) + 2), 32'd32);
    end
    wait_drained();
  endtask

  task automatic test_long_burst();
    vaddr_pkg::addr_t base;
    vaddr_pkg::addr_t exp_addr;
    logic             got_err;
    int               exp_beats;
    int               left;
    int               total;
    base     = 32'h3000_0000;
    exp_addr = base;
    left     = 600;
    total    = 0;
    clear_logs();
    // 4800 bytes from a page start, cut at 256 beats and at the page end
    send_req(base, 16'd600, '0, vaddr_pkg::EW64, 1'b1, 1'b1);
    wait_ack(got_err);
    check_value("long burst error", 32'(got_err), 32'd0);
    check_value("long burst AR count", ar_log.size(), 32'd3);
    foreach (ar_log[k]) begin
      // Shortest of the page rest, a full 256 beat burst and the beats still needed
      exp_beats = (4096 - int'(exp_addr & 32'hFFF)) / 8;
      if (exp_beats > 256) begin
        exp_beats = 256;
      end
      if (exp_beats > left) begin
        exp_beats = left;
      end
      check_value("long burst address", ar_log[k].addr, exp_addr);
      check_value("long burst length", 32'(ar_log[k].len), 32'(exp_beats - 1));
      exp_addr += 32'(exp_beats * 8);
      left     -= exp_beats;
      total    += int'(ar_log[k].len) + 1;
    end
    check_value("long burst total beats", total, 32'd600);
    wait_drained();
  endtask

  task automatic test_strided();
    vaddr_pkg::addr_t   base;
    vaddr_pkg::stride_t stride;
    logic               got_err;
    base   = 32'h4000_0002;
    stride = 32'h46;
    clear_logs();
    send_req(base, 16'd6, stride, vaddr_pkg::EW16, 1'b1, 1'b0);
    wait_ack(got_err);
    check_value("strided error", 32'(got_err), 32'd0);
    check_value("strided AR count", ar_log.size(), 32'd6);
    foreach (ar_log[k]) begin
      check_value("strided address", ar_log[k].addr, base + stride * 32'(k));
      check_value("strided length", 32'(ar_log[k].len), 32'd0);
      check_value("strided size", 32'(ar_log[k].size), 32'd1);
    end
    wait_drained();
  endtask

  task automatic test_misaligned();
    logic got_err;
    clear_logs();
    // Halfword offset on a word access
    send_req(32'h5000_0002, 16'd4, '0, vaddr_pkg::EW32, 1'b1, 1'b1);
    wait_ack(got_err);
    check_value("misaligned error", 32'(got_err), 32'd1);
    check_value("misaligned AR count", ar_log.size(), 32'd0);
    check_value("misaligned AW count", aw_log.size(), 32'd0);
    check_value("misaligned queue entries", queue_model.size(), 32'd0);
    check_value("misaligned queue valid", 32'(lsu_cmd_valid), 32'd0);
  endtask

  task automatic test_backpressure();
    vaddr_pkg::addr_t base;
    logic             got_err;
    base = 32'h6000_0000;
    clear_logs();
    @(negedge clk);
    rand_ready = 1'b1;
    lsu_mode   = LsuHold;
    // Six strided loads against a four entry queue that is not drained
    send_req(base, 16'd6, 32'h100, vaddr_pkg::EW32, 1'b1, 1'b0);
    wait_ar_count(4);
    repeat (10) @(negedge clk);
    check_value("AR count with a full queue", ar_log.size(), 32'd4);
    check_value("queue valid while held", 32'(lsu_cmd_valid), 32'd1);
    lsu_mode = LsuRandom;
    wait_ack(got_err);
    check_value("stalled load error", 32'(got_err), 32'd0);
    check_value("stalled load AR count", ar_log.size(), 32'd6);
    foreach (ar_log[k]) begin
      check_value("stalled load address", ar_log[k].addr, base + 32'h100 * 32'(k));
    end
    wait_drained();

    // Loads left in the queue hold back the following store
    clear_logs();
    lsu_mode = LsuHold;
    send_req(base, 16'd3, 32'h100, vaddr_pkg::EW32, 1'b1, 1'b0);
    wait_ack(got_err);
    send_req(32'h6100_0000, 16'd8, '0, vaddr_pkg::EW64, 1'b0, 1'b1);
    repeat (15) @(negedge clk);
    check_value("AW count behind loads", aw_log.size(), 32'd0);
    check_value("loads still queued", queue_model.size(), 32'd3);
    lsu_mode = LsuRandom;
    wait_ack(got_err);
    check_value("store error", 32'(got_err), 32'd0);
    check_value("store AW count", aw_log.size(), 32'd1);
    if (aw_log.size() == 1) begin
      check_value("store address", aw_log[0].addr, 32'h6100_0000);
      check_value("store length", 32'(aw_log[0].len), 32'd7);
    end
    wait_drained();
    rand_ready = 1'b0;
    lsu_mode   = LsuOpen;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n         = 1'b0;
    req           = '0;
    req_valid     = 1'b0;
    ar_ready      = 1'b1;
    aw_ready      = 1'b1;
    lsu_cmd_ready = 1'b1;
    rand_ready    = 1'b0;
    lsu_mode      = LsuOpen;
    errors        = 0;
    checks        = 0;
    repeat (4) @(posedge clk);
    // All outputs quiet while reset is held
    @(negedge clk);
    check_value("outputs in reset",
                32'({req_ready, ar_valid, aw_valid, lsu_cmd_valid, ack, err}), 32'd0);
    @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_single_burst();
    test_page_cross();
    test_long_burst();
    test_strided();
    test_misaligned();
    test_backpressure();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
design/vaddr_pkg.sv
design/vaddr_frontend.sv
design/burst_splitter.sv
design/lsu_cmd_queue.sv
design/vaddr_gen_top.sv
testbench/vaddr_gen_props.sv
testbench/tb_vaddr_gen.sv

// ==== Makefile ====
# Verilator build, run and lint of the vector address generator testbench

VERILATOR ?= verilator
TOP       ?= tb_vaddr_gen
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= *** PASSED ***

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The run fails unless the pass message shows up in the output
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
